//--- src/sd_dat_pkg.sv
/*
 * Shared definitions for the 4-bit SD data-line physical layer.
 * Framing covers start and end nibbles only; there is no CRC16 field.
 */

`default_nettype none

package sd_dat_pkg;

   ////////////////////////////////////////////////////////////
   // Block framing on DAT[3:0]
   ////////////////////////////////////////////////////////////

   localparam logic [3:0] START_NIBBLE = 4'h0;   // All lines low
   localparam logic [3:0] END_NIBBLE   = 4'hF;   // All lines high

   ////////////////////////////////////////////////////////////
   // FSM encodings
   ////////////////////////////////////////////////////////////

   // Transfer controller
   typedef enum logic [2:0] {
      IDLE,
      WRITE_BLK,
      WRITE_BUSY,    // Card holds DAT0 low after a block
      READ_BLK,
      DONE
   } phys_state_e;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_END} tx_state_e;

   typedef enum logic [1:0] {RX_IDLE, RX_HUNT, RX_DATA, RX_END} rx_state_e;

endpackage

`default_nettype wire

//--- src/dat_tx_serializer.sv
/*
 * Sends one framed block on DAT[3:0], MSB nibble of each word first.
 * The FIFO must answer a read strobe with data in the next cycle.
 * block_sz must be a multiple of FIFO_WIDTH/8 bytes and not zero.
 */

`timescale 1ns/100ps
`default_nettype none

module dat_tx_serializer #(
   parameter int FIFO_WIDTH     = 32,
   parameter int BLOCK_SZ_WIDTH = 12
) (
   input  wire logic                      sd_clk,
   input  wire logic                      rst_L,
   input  wire logic                      blk_start,
   input  wire logic [BLOCK_SZ_WIDTH-1:0] block_sz,
   input  wire logic [FIFO_WIDTH-1:0]     tx_buf_dout,
   output logic                           tx_buf_rd_enb,
   output logic [3:0]                     dat_dout,
   output logic                           dat_oe,
   output logic                           blk_done
);

   localparam int NPW   = FIFO_WIDTH / 4;        // Nibbles per word
   localparam int IDX_W = (NPW > 1) ? $clog2(NPW) : 1;
   localparam int NL_W  = BLOCK_SZ_WIDTH + 1;    // Two nibbles per byte

   sd_dat_pkg::tx_state_e   state;
   logic [IDX_W-1:0]        nib_idx;             // Nibble on the bus
   logic [NL_W-1:0]         nib_left;            // Data nibbles still to send
   logic                    word_pend;           // FIFO word valid this cycle
   logic [FIFO_WIDTH-1:0]   word_q;
   logic [FIFO_WIDTH-1:0]   cur_word;
   logic                    last_of_word;
   logic                    last_of_blk;

   assign last_of_word = (nib_idx == IDX_W'(NPW - 1));
   assign last_of_blk  = (nib_left == NL_W'(1));

   // Fresh FIFO data bypasses the holding register
   assign cur_word = word_pend ? tx_buf_dout : word_q;

   // First word on block start, then one just ahead of each word boundary
   assign tx_buf_rd_enb = (state == sd_dat_pkg::TX_IDLE && blk_start) ||
                          (state == sd_dat_pkg::TX_DATA && last_of_word && !last_of_blk);

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state     <= sd_dat_pkg::TX_IDLE;
         nib_idx   <= '0;
         nib_left  <= '0;
         word_pend <= 1'b0;
      end else begin
         word_pend <= tx_buf_rd_enb;
         case (state)
            sd_dat_pkg::TX_IDLE: begin
               if (blk_start) begin
                  nib_left <= {block_sz, 1'b0};
                  state    <= sd_dat_pkg::TX_START;
               end
            end
            sd_dat_pkg::TX_START: begin
               nib_idx <= '0;
               state   <= sd_dat_pkg::TX_DATA;
            end
            sd_dat_pkg::TX_DATA: begin
               nib_left <= nib_left - NL_W'(1);
               nib_idx  <= last_of_word ? '0 : nib_idx + IDX_W'(1);
               if (last_of_blk)
                  state <= sd_dat_pkg::TX_END;
            end
            default: state <= sd_dat_pkg::TX_IDLE;   // TX_END lasts one cycle
         endcase
      end
   end

   // Holds the FIFO word from the cycle it is presented
   always_ff @(posedge sd_clk) begin
      if (word_pend)
         word_q <= tx_buf_dout;
   end

   ////////////////////////////////////////////////////////////
   // Bus drive
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (state)
         sd_dat_pkg::TX_START: dat_dout = sd_dat_pkg::START_NIBBLE;
         sd_dat_pkg::TX_DATA:  dat_dout = cur_word[FIFO_WIDTH-1-4*int'(nib_idx) -: 4];
         sd_dat_pkg::TX_END:   dat_dout = sd_dat_pkg::END_NIBBLE;
         default:              dat_dout = 4'hF;     // Idle lines sit high
      endcase
   end

   assign dat_oe   = (state != sd_dat_pkg::TX_IDLE);
   assign blk_done = (state == sd_dat_pkg::TX_END);   // Same cycle as end nibble

endmodule

`default_nettype wire

//--- src/dat_rx_deserializer.sv
/*
 * Receives one framed block from DAT[3:0] into FIFO words, MSB first.
 * No timeout: the hunt for the start nibble waits forever.
 * block_sz must be a multiple of FIFO_WIDTH/8 bytes and not zero.
 */

`timescale 1ns/100ps
`default_nettype none

module dat_rx_deserializer #(
   parameter int FIFO_WIDTH     = 32,
   parameter int BLOCK_SZ_WIDTH = 12
) (
   input  wire logic                      sd_clk,
   input  wire logic                      rst_L,
   input  wire logic                      blk_start,
   input  wire logic [BLOCK_SZ_WIDTH-1:0] block_sz,
   input  wire logic [3:0]                dat_din,
   output logic                           rx_buf_wr_enb,
   output logic [FIFO_WIDTH-1:0]          rx_buf_din,
   output logic                           blk_done,
   output logic                           end_err
);

   localparam int NPW   = FIFO_WIDTH / 4;
   localparam int IDX_W = (NPW > 1) ? $clog2(NPW) : 1;
   localparam int NL_W  = BLOCK_SZ_WIDTH + 1;

   sd_dat_pkg::rx_state_e   state;
   logic [IDX_W-1:0]        nib_idx;             // Position of the sampled nibble
   logic [NL_W-1:0]         nib_left;
   logic [FIFO_WIDTH-1:0]   word_q;              // Shift register
   logic [FIFO_WIDTH-1:0]   next_word;
   logic                    last_of_word;

   assign next_word    = {word_q[FIFO_WIDTH-5:0], dat_din};
   assign last_of_word = (nib_idx == IDX_W'(NPW - 1));

   ////////////////////////////////////////////////////////////
   // Block framing FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state         <= sd_dat_pkg::RX_IDLE;
         nib_idx       <= '0;
         nib_left      <= '0;
         rx_buf_wr_enb <= 1'b0;
      end else begin
         rx_buf_wr_enb <= 1'b0;
         case (state)
            sd_dat_pkg::RX_IDLE: begin
               if (blk_start) begin
                  nib_left <= {block_sz, 1'b0};
                  state    <= sd_dat_pkg::RX_HUNT;
               end
            end
            sd_dat_pkg::RX_HUNT: begin
               nib_idx <= '0;
               if (dat_din == sd_dat_pkg::START_NIBBLE)
                  state <= sd_dat_pkg::RX_DATA;
            end
            sd_dat_pkg::RX_DATA: begin
               nib_left <= nib_left - NL_W'(1);
               if (last_of_word) begin
                  nib_idx       <= '0;
                  rx_buf_wr_enb <= 1'b1;    // Word is out next cycle
               end else begin
                  nib_idx <= nib_idx + IDX_W'(1);
               end
               if (nib_left == NL_W'(1))
                  state <= sd_dat_pkg::RX_END;
            end
            default: state <= sd_dat_pkg::RX_IDLE;
         endcase
      end
   end

   // Payload path
   always_ff @(posedge sd_clk) begin
      if (state == sd_dat_pkg::RX_DATA) begin
         word_q <= next_word;
         if (last_of_word)
            rx_buf_din <= next_word;
      end
   end

   // End nibble is checked as it is sampled
   assign blk_done = (state == sd_dat_pkg::RX_END);
   assign end_err  = blk_done && (dat_din != sd_dat_pkg::END_NIBBLE);

endmodule

`default_nettype wire

//--- src/dat_phys_ctrl.sv
/*
 * Transfer FSM for multi-block writes and reads on the 4-bit bus.
 * Flags are single-cycle strobes seen only in IDLE; conflicting or
 * empty requests (zero size or count) start nothing.
 * xfer_err holds until the next transfer starts.
 */

`timescale 1ns/100ps
`default_nettype none

module dat_phys_ctrl #(
   parameter int BLOCK_SZ_WIDTH  = 12,
   parameter int BLOCK_CNT_WIDTH = 16
) (
   input  wire logic                       sd_clk,
   input  wire logic                       rst_L,
   input  wire logic                       write_flag,
   input  wire logic                       read_flag,
   input  wire logic [BLOCK_SZ_WIDTH-1:0]  block_sz,
   input  wire logic [BLOCK_CNT_WIDTH-1:0] block_cnt,
   input  wire logic                       card_busy,
   input  wire logic                       tx_blk_done,
   input  wire logic                       rx_blk_done,
   input  wire logic                       rx_end_err,
   output logic                            tx_blk_start,
   output logic                            rx_blk_start,
   output logic                            dat_phys_busy,
   output logic                            tf_finished,
   output logic                            xfer_err
);

   // Cycles to ignore DAT0 after an end nibble
   localparam logic [1:0] MIN_BUSY_WAIT = 2'd2;

   sd_dat_pkg::phys_state_e      state;
   logic [BLOCK_CNT_WIDTH-1:0]   blk_left;
   logic [1:0]                   wait_cnt;
   logic                         err_q;
   logic                         xfer_ok;
   logic                         start_wr;
   logic                         start_rd;

   assign xfer_ok  = (block_sz != '0) && (block_cnt != '0);
   assign start_wr = write_flag && !read_flag && !card_busy && xfer_ok;
   assign start_rd = read_flag && !write_flag && xfer_ok;

   ////////////////////////////////////////////////////////////
   // Transfer FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state        <= sd_dat_pkg::IDLE;
         blk_left     <= '0;
         wait_cnt     <= '0;
         err_q        <= 1'b0;
         tx_blk_start <= 1'b0;
         rx_blk_start <= 1'b0;
      end else begin
         tx_blk_start <= 1'b0;
         rx_blk_start <= 1'b0;
         case (state)
            sd_dat_pkg::IDLE: begin
               if (start_wr) begin
                  blk_left     <= block_cnt;
                  err_q        <= 1'b0;
                  tx_blk_start <= 1'b1;
                  state        <= sd_dat_pkg::WRITE_BLK;
               end else if (start_rd) begin
                  blk_left     <= block_cnt;
                  err_q        <= 1'b0;
                  rx_blk_start <= 1'b1;
                  state        <= sd_dat_pkg::READ_BLK;
               end
            end
            sd_dat_pkg::WRITE_BLK: begin
               if (tx_blk_done) begin
                  blk_left <= blk_left - BLOCK_CNT_WIDTH'(1);
                  wait_cnt <= MIN_BUSY_WAIT;
                  state    <= sd_dat_pkg::WRITE_BUSY;
               end
            end
            sd_dat_pkg::WRITE_BUSY: begin
               if (wait_cnt != '0) begin
                  wait_cnt <= wait_cnt - 2'd1;   // Give the card time to pull DAT0
               end else if (!card_busy) begin
                  if (blk_left != '0) begin
                     tx_blk_start <= 1'b1;
                     state        <= sd_dat_pkg::WRITE_BLK;
                  end else begin
                     state <= sd_dat_pkg::DONE;
                  end
               end
            end
            sd_dat_pkg::READ_BLK: begin
               if (rx_blk_done) begin
                  err_q    <= err_q | rx_end_err;   // Sticky over all blocks
                  blk_left <= blk_left - BLOCK_CNT_WIDTH'(1);
                  if (blk_left == BLOCK_CNT_WIDTH'(1))
                     state <= sd_dat_pkg::DONE;
                  else
                     rx_blk_start <= 1'b1;
               end
            end
            default: state <= sd_dat_pkg::IDLE;   // DONE
         endcase
      end
   end

   // Status
   assign dat_phys_busy = (state != sd_dat_pkg::IDLE);
   assign tf_finished   = (state == sd_dat_pkg::DONE);
   assign xfer_err      = err_q;

endmodule

`default_nettype wire

//--- src/sd_dat_phys.sv
/*
 * 4-bit SD data-line physical layer, no CRC16 and no 1-bit mode.
 * dat_oe selects the pad direction outside this block.
 * FIFOs are external and must never run full or empty.
 */

`timescale 1ns/100ps
`default_nettype none

module sd_dat_phys #(
   parameter int FIFO_WIDTH      = 32,
   parameter int BLOCK_SZ_WIDTH  = 12,
   parameter int BLOCK_CNT_WIDTH = 16
) (
   input  wire logic                       sd_clk,
   input  wire logic                       rst_L,
   input  wire logic                       write_flag,
   input  wire logic                       read_flag,
   input  wire logic [BLOCK_SZ_WIDTH-1:0]  block_sz,
   input  wire logic [BLOCK_CNT_WIDTH-1:0] block_cnt,
   input  wire logic [FIFO_WIDTH-1:0]      tx_buf_dout,
   input  wire logic [3:0]                 dat_din,
   output logic                            tx_buf_rd_enb,
   output logic                            rx_buf_wr_enb,
   output logic [FIFO_WIDTH-1:0]           rx_buf_din,
   output logic [3:0]                      dat_dout,
   output logic                            dat_oe,
   output logic                            dat_phys_busy,
   output logic                            tf_finished,
   output logic                            xfer_err,
   output logic                            sdc_busy_L
);

   logic card_busy;      // DAT0 held low by the card
   logic tx_blk_start;
   logic rx_blk_start;
   logic tx_blk_done;
   logic rx_blk_done;
   logic rx_end_err;

   assign sdc_busy_L = dat_din[0];
   assign card_busy  = ~dat_din[0];

   dat_phys_ctrl #(
      .BLOCK_SZ_WIDTH (BLOCK_SZ_WIDTH),
      .BLOCK_CNT_WIDTH(BLOCK_CNT_WIDTH)
   ) u_ctrl (
      .sd_clk       (sd_clk),
      .rst_L        (rst_L),
      .write_flag   (write_flag),
      .read_flag    (read_flag),
      .block_sz     (block_sz),
      .block_cnt    (block_cnt),
      .card_busy    (card_busy),
      .tx_blk_done  (tx_blk_done),
      .rx_blk_done  (rx_blk_done),
      .rx_end_err   (rx_end_err),
      .tx_blk_start (tx_blk_start),
      .rx_blk_start (rx_blk_start),
      .dat_phys_busy(dat_phys_busy),
      .tf_finished  (tf_finished),
      .xfer_err     (xfer_err)
   );

   dat_tx_serializer #(
      .FIFO_WIDTH    (FIFO_WIDTH),
      .BLOCK_SZ_WIDTH(BLOCK_SZ_WIDTH)
   ) u_tx (
      .sd_clk       (sd_clk),
      .rst_L        (rst_L),
      .blk_start    (tx_blk_start),
      .block_sz     (block_sz),
      .tx_buf_dout  (tx_buf_dout),
      .tx_buf_rd_enb(tx_buf_rd_enb),
      .dat_dout     (dat_dout),
      .dat_oe       (dat_oe),
      .blk_done     (tx_blk_done)
   );

   dat_rx_deserializer #(
      .FIFO_WIDTH    (FIFO_WIDTH),
      .BLOCK_SZ_WIDTH(BLOCK_SZ_WIDTH)
   ) u_rx (
      .sd_clk       (sd_clk),
      .rst_L        (rst_L),
      .blk_start    (rx_blk_start),
      .block_sz     (block_sz),
      .dat_din      (dat_din),
      .rx_buf_wr_enb(rx_buf_wr_enb),
      .rx_buf_din   (rx_buf_din),
      .blk_done     (rx_blk_done),
      .end_err      (rx_end_err)
   );

endmodule

`default_nettype wire

//--- test/dat_phys_props.sv
/*
 * Concurrent checks on the PHY controller strobes and DAT direction.
 * Bound into the PHY top level, reading the FSM state through u_ctrl.
 */

`timescale 1ns/100ps
`default_nettype none

module dat_phys_props (
   input wire logic                    sd_clk,
   input wire logic                    rst_L,
   input wire sd_dat_pkg::phys_state_e state,
   input wire logic                    tx_blk_start,
   input wire logic                    rx_blk_start,
   input wire logic                    rx_blk_done,
   input wire logic                    tf_finished,
   input wire logic                    dat_oe
);

   // New block only from IDLE or after the card released busy
   a_tx_start: assert property (@(posedge sd_clk) disable iff (!rst_L)
      tx_blk_start |-> state == sd_dat_pkg::WRITE_BLK && !rx_blk_start &&
         ($past(state) == sd_dat_pkg::IDLE || $past(state) == sd_dat_pkg::WRITE_BUSY))
      else $error("tx_blk_start while a block was running");

   // Next read block only once the previous one is done
   a_rx_start: assert property (@(posedge sd_clk) disable iff (!rst_L)
      rx_blk_start |-> state == sd_dat_pkg::READ_BLK && !tx_blk_start &&
         ($past(state) == sd_dat_pkg::IDLE || $past(rx_blk_done)))
      else $error("rx_blk_start while a read block was running");

   a_finish: assert property (@(posedge sd_clk) disable iff (!rst_L)
      tf_finished |-> ($past(state) == sd_dat_pkg::WRITE_BUSY ||
                       ($past(state) == sd_dat_pkg::READ_BLK && $past(rx_blk_done))))
      else $error("tf_finished without a transfer before it");

   a_bus_dir: assert property (@(posedge sd_clk) disable iff (!rst_L)
      state == sd_dat_pkg::READ_BLK |-> !dat_oe)
      else $error("Host drove DAT during a read");

endmodule

bind sd_dat_phys dat_phys_props u_props (
   .sd_clk      (sd_clk),
   .rst_L       (rst_L),
   .state       (u_ctrl.state),
   .tx_blk_start(tx_blk_start),
   .rx_blk_start(rx_blk_start),
   .rx_blk_done (rx_blk_done),
   .tf_finished (tf_finished),
   .dat_oe      (dat_oe)
);

`default_nettype wire

//--- test/tb_sd_dat_phys.sv
/*
 * Testbench for the 4-bit SD data-line PHY. Models the TX FIFO and a card
 * that holds DAT0 busy after writes and sends framed read blocks.
 * Block size is fixed at BLK_BYTES. The run stops at the first mismatch.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_sd_dat_phys;

   localparam int FIFO_WIDTH      = 32;
   localparam int BLOCK_SZ_WIDTH  = 12;
   localparam int BLOCK_CNT_WIDTH = 16;
   localparam int BLK_BYTES       = 16;
   localparam int NPW             = FIFO_WIDTH / 4;        // Nibbles per word
   localparam int BLK_NIBS        = 2 * BLK_BYTES + 2;     // Framed block
   localparam int MAX_BUSY        = 8;
   localparam int MAX_IDLE        = 9;
   localparam int TOTAL_BLKS      = 12;
   localparam int WATCHDOG_NS     = (TOTAL_BLKS * (BLK_NIBS + MAX_BUSY + MAX_IDLE + 8) + 400) * 10;

   typedef logic [3:0]            nib_q_t[$];
   typedef logic [FIFO_WIDTH-1:0] word_q_t[$];

   logic                       sd_clk;
   logic                       rst_L;
   logic                       write_flag;
   logic                       read_flag;
   logic [BLOCK_SZ_WIDTH-1:0]  block_sz;
   logic [BLOCK_CNT_WIDTH-1:0] block_cnt;
   logic [FIFO_WIDTH-1:0]      tx_buf_dout;
   logic [3:0]                 dat_din;
   logic                       tx_buf_rd_enb;
   logic                       rx_buf_wr_enb;
   logic [FIFO_WIDTH-1:0]      rx_buf_din;
   logic [3:0]                 dat_dout;
   logic                       dat_oe;
   logic                       dat_phys_busy;
   logic                       tf_finished;
   logic                       xfer_err;
   logic                       sdc_busy_L;

   word_q_t fifo_q;             // TX FIFO contents
   word_q_t exp_word;           // Words expected on rx_buf_din
   nib_q_t  exp_nib;            // Nibbles expected on dat_dout
   nib_q_t  rd_stream;          // Card drive for reads
   int      busy_q[$];          // Busy length per write block
   logic    exp_err       = 1'b0;
   logic    card_hold_low = 1'b0;
   int      exp_fin       = 0;
   int      fin_cnt       = 0;

   sd_dat_phys #(
      .FIFO_WIDTH     (FIFO_WIDTH),
      .BLOCK_SZ_WIDTH (BLOCK_SZ_WIDTH),
      .BLOCK_CNT_WIDTH(BLOCK_CNT_WIDTH)
   ) u_dut (.*);

   initial begin
      sd_clk = 1'b0;
      forever #5 sd_clk = ~sd_clk;
   end

   ////////////////////////////////////////////////////////////
   // Reference model and checks
   ////////////////////////////////////////////////////////////

   // Per block: start nibble, words MSB nibble first, end nibble
   function automatic nib_q_t ref_stream(input word_q_t words, input int blk_bytes);
      nib_q_t s;
      int     wpb;
      wpb = 2 * blk_bytes / NPW;
      for (int w = 0; w < words.size(); w++) begin
         if (w % wpb == 0)
            s.push_back(sd_dat_pkg::START_NIBBLE);
         for (int n = NPW - 1; n >= 0; n--)
            s.push_back(words[w][4*n +: 4]);
         if (w % wpb == wpb - 1)
            s.push_back(sd_dat_pkg::END_NIBBLE);
      end
      return s;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "Simulation stopped at the first failing check");
   endtask

   task automatic check_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp)
         stop_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_word(input string name, input logic [FIFO_WIDTH-1:0] got,
                             input logic [FIFO_WIDTH-1:0] exp);
      if (got !== exp)
         stop_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // Outputs are sampled mid-cycle while inputs move 1 ns after the rising edge
   initial begin : compare_proc
      forever begin
         @(negedge sd_clk);
         if (rst_L) begin
            if (dat_oe && dat_din[0] === 1'b0)
               stop_run("Host drove DAT while the card held DAT0 low");
            else if (dat_oe && exp_nib.size() == 0)
               stop_run("dat_oe went high with no block expected");
            else if (dat_oe)
               check_nibble("dat_dout", dat_dout, exp_nib.pop_front());
            if (rx_buf_wr_enb && exp_word.size() == 0)
               stop_run("rx_buf_wr_enb pulsed with no word expected");
            else if (rx_buf_wr_enb)
               check_word("rx_buf_din", rx_buf_din, exp_word.pop_front());
            if (tf_finished) begin
               fin_cnt++;
               check_flag("xfer_err", xfer_err, exp_err);
            end
            check_flag("sdc_busy_L", sdc_busy_L, dat_din[0]);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // FIFO and card models
   ////////////////////////////////////////////////////////////

   initial begin : tx_fifo_model
      logic rd;
      tx_buf_dout = '0;
      forever begin
         @(negedge sd_clk);
         rd = tx_buf_rd_enb;
         @(posedge sd_clk);
         #1;
         if (rd === 1'b1 && fifo_q.size() == 0)
            stop_run("TX FIFO read while empty");
         else if (rd === 1'b1)
            tx_buf_dout = fifo_q.pop_front();      // Valid the cycle after the strobe
      end
   end

   initial begin : card_model
      int   busy_left;
      logic oe_prev;
      busy_left = 0;
      oe_prev   = 1'b0;
      dat_din   = 4'hF;
      forever begin
         @(negedge sd_clk);
         if (oe_prev && !dat_oe && busy_q.size() != 0)
            busy_left = busy_q.pop_front();      // Block just ended
         oe_prev = dat_oe;
         @(posedge sd_clk);
         #1;
         if (rd_stream.size() != 0) begin
            dat_din = rd_stream.pop_front();
         end else if (busy_left > 0 || card_hold_low) begin
            dat_din = 4'hE;                      // DAT0 low
            busy_left = (busy_left > 0) ? busy_left - 1 : 0;
         end else begin
            dat_din = 4'hF;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      stop_run($sformatf("Timeout after %0d ns, a transfer never finished", WATCHDOG_NS));
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   task automatic drive_flags(input logic wr, input logic rd, input int n_blk);
      @(posedge sd_clk);
      #1;
      write_flag = wr;
      read_flag  = rd;
      block_cnt  = BLOCK_CNT_WIDTH'(n_blk);
      @(posedge sd_clk);
      #1;
      write_flag = 1'b0;
      read_flag  = 1'b0;
   endtask

   task automatic wait_finish();
      do @(negedge sd_clk); while (!tf_finished);
      @(negedge sd_clk);
      if (exp_nib.size() != 0 || exp_word.size() != 0 || fifo_q.size() != 0 || busy_q.size() != 0)
         stop_run("Transfer finished with data still queued in the models");
      if (fin_cnt != exp_fin)
         stop_run($sformatf("Saw %0d transfer ends but expected %0d", fin_cnt, exp_fin));
   endtask

   task automatic expect_idle(input int n);
      repeat (n) begin
         @(negedge sd_clk);
         if (dat_phys_busy)
            stop_run("An ignored request made dat_phys_busy rise");
      end
   endtask

   // poke adds a read flag and a double flag while the write runs
   task automatic run_write(input int n_blk, input logic poke);
      word_q_t words;
      nib_q_t  stream;
      for (int i = 0; i < n_blk * 2 * BLK_BYTES / NPW; i++)
         words.push_back($urandom());
      foreach (words[i])
         fifo_q.push_back(words[i]);
      stream = ref_stream(words, BLK_BYTES);
      foreach (stream[i])
         exp_nib.push_back(stream[i]);
      for (int b = 0; b < n_blk; b++)
         busy_q.push_back($urandom_range(MAX_BUSY, 1));
      exp_err = 1'b0;
      exp_fin++;
      drive_flags(1'b1, 1'b0, n_blk);
      if (poke) begin
         repeat (8) @(posedge sd_clk);
         drive_flags(1'b0, 1'b1, n_blk);
         drive_flags(1'b1, 1'b1, n_blk);
      end
      wait_finish();
   endtask

   // bad_blk < 0 means every end nibble is good
   task automatic run_read(input int n_blk, input int bad_blk);
      word_q_t words;
      nib_q_t  stream;
      @(negedge sd_clk);
      for (int i = 0; i < n_blk * 2 * BLK_BYTES / NPW; i++)
         words.push_back($urandom());
      foreach (words[i])
         exp_word.push_back(words[i]);
      stream = ref_stream(words, BLK_BYTES);
      for (int i = 0; i < stream.size(); i++) begin
         if (i % BLK_NIBS == 0)
            repeat ($urandom_range(MAX_IDLE, 2)) rd_stream.push_back(4'hF);   // Hunt delay
         if (i % BLK_NIBS == BLK_NIBS - 1 && i / BLK_NIBS == bad_blk)
            rd_stream.push_back(4'h7);
         else
            rd_stream.push_back(stream[i]);
      end
      exp_err = (bad_blk >= 0);
      exp_fin++;
      drive_flags(1'b0, 1'b1, n_blk);
      wait_finish();
   endtask

   initial begin : main_seq
      void'($urandom(87));
      rst_L      = 1'b0;
      write_flag = 1'b0;
      read_flag  = 1'b0;
      block_sz   = BLOCK_SZ_WIDTH'(BLK_BYTES);
      block_cnt  = '0;
      repeat (3) @(posedge sd_clk);
      #1;
      rst_L = 1'b1;
      @(negedge sd_clk);
      check_flag("dat_oe", dat_oe, 1'b0);
      check_flag("dat_phys_busy", dat_phys_busy, 1'b0);
      check_flag("tf_finished", tf_finished, 1'b0);
      check_flag("xfer_err", xfer_err, 1'b0);

      run_write(3, 1'b0);                  // Busy after every block
      card_hold_low = 1'b1;
      repeat (2) @(posedge sd_clk);
      drive_flags(1'b1, 1'b0, 2);          // Refused while DAT0 is low
      expect_idle(6);
      card_hold_low = 1'b0;
      repeat (2) @(negedge sd_clk);
      run_write(2, 1'b0);
      run_read(3, -1);
      run_read(2, 1);                      // Second block has a bad end nibble
      drive_flags(1'b1, 1'b1, 2);
      expect_idle(6);
      run_write(2, 1'b1);

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
src/sd_dat_pkg.sv
src/dat_tx_serializer.sv
src/dat_rx_deserializer.sv
src/dat_phys_ctrl.sv
src/sd_dat_phys.sv
test/dat_phys_props.sv
test/tb_sd_dat_phys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SD DAT PHY testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sd_dat_phys -f sources.f -o sim_tb

# A failing run exits nonzero, the log search below decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
   exit 0
else
   exit 1
fi
